// File: design/exe_ops_pkg.sv
package exe_ops_pkg;

    // bit positions of the one-hot alu operation
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // multiply: low word, signed high, unsigned high
    localparam int MUL_LO  = 0;
    localparam int MUL_HI  = 1;
    localparam int MUL_HIU = 2;

    // load kinds
    localparam int LD_B  = 0;
    localparam int LD_H  = 1;
    localparam int LD_W  = 2;
    localparam int LD_BU = 3;
    localparam int LD_HU = 4;

    // store kinds
    localparam int ST_B = 0;
    localparam int ST_H = 1;
    localparam int ST_W = 2;

    // stable counter reads
    localparam int RDCNT_LO = 0;
    localparam int RDCNT_HI = 1;

    typedef logic [11:0] alu_op_t;
    typedef logic [2:0]  mul_op_t;
    typedef logic [4:0]  ld_op_t;
    typedef logic [2:0]  st_op_t;
    typedef logic [1:0]  rdcnt_op_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // one decoded instruction from decode
    typedef struct packed {
        alu_op_t   alu_op;
        mul_op_t   mul_op;
        ld_op_t    ld_op;
        st_op_t    st_op;
        rdcnt_op_t rdcnt_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        reg_idx_t  dest;
        word_t     imm;
        word_t     rj_value;
        word_t     rkd_value;
        word_t     pc;
    } de_to_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     gr_we;
        logic     res_from_mem;
        logic     mem_we;
        ld_op_t   ld_op;
        logic [1:0] ls_offset;
        word_t    rkd_value;
        logic     ale;
        logic     mem_req_made;
    } ex_to_mem_t;

    // dest is zero when there is nothing to forward
    typedef struct packed {
        reg_idx_t dest;
        word_t    data;
        logic     block;
    } ex_forward_t;

endpackage

// File: design/data_port_pkg.sv
package data_port_pkg;

    // access size as seen on the data sram port
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    typedef logic [3:0] strb_t;

    // one request on the data sram port
    typedef struct packed {
        logic         wr;
        access_size_t size;
        strb_t        wstrb;
        logic [31:0]  addr;
        logic [31:0]  wdata;
    } data_req_t;

    // strobe for a full word store
    localparam strb_t STRB_WORD = 4'b1111;

    // strobes for the two half-word lanes
    localparam strb_t STRB_HALF_LO = 4'b0011;
    localparam strb_t STRB_HALF_HI = 4'b1100;

    // loads never write a lane
    localparam strb_t STRB_NONE = 4'b0000;

endpackage

// File: design/exe_stage_reg.sv
module exe_stage_reg (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  exe_ops_pkg::de_to_ex_t  in_inst,

    output logic                    stage_valid,
    output exe_ops_pkg::de_to_ex_t  stage_inst,

    input  logic                    lsu_done,

    output logic                    out_valid,
    input  logic                    out_ready
);

    logic accept;

    // held back until memory side is done with the instruction
    assign out_valid = stage_valid && lsu_done;

    // empty, or the current one leaves on this edge
    assign in_ready = !stage_valid || (out_valid && out_ready);

    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (in_ready) begin
            stage_valid <= in_valid;
        end
    end

    // instruction register, loaded when accepted
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_inst <= in_inst;
        end
    end

endmodule

// File: design/exe_compute.sv
module exe_compute #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                    clk,
    input  logic                    reset,
    input  exe_ops_pkg::de_to_ex_t  stage_inst,
    output exe_ops_pkg::word_t      alu_result,
    output exe_ops_pkg::word_t      result
);
    import exe_ops_pkg::*;

    logic                     src_sign;
    logic [32:0]              src1;
    logic [32:0]              src2;
    logic signed [65:0]       mul_prod;

    word_t                    add_res;
    word_t                    sub_res;
    word_t                    slt_res;
    word_t                    sltu_res;
    word_t                    sll_res;
    word_t                    srl_res;
    word_t                    sra_res;
    word_t                    alu_out;

    word_t                    mul_lo;
    word_t                    mul_hi;

    logic [COUNTER_WIDTH-1:0] stable_cnt;
    word_t                    cnt_lo;
    word_t                    cnt_hi;

    // operand select
    assign src1[31:0] = stage_inst.src1_is_pc  ? stage_inst.pc  : stage_inst.rj_value;
    assign src2[31:0] = stage_inst.src2_is_imm ? stage_inst.imm : stage_inst.rkd_value;

    // extra top bit turns the 33-bit signed multiply into signed or unsigned
    assign src_sign = stage_inst.mul_op[MUL_LO] | stage_inst.mul_op[MUL_HI];
    assign src1[32] = src_sign & src1[31];
    assign src2[32] = src_sign & src2[31];

    // alu
    assign add_res  = src1[31:0] + src2[31:0];
    assign sub_res  = src1[31:0] - src2[31:0];
    assign slt_res  = {31'd0, $signed(src1[31:0]) < $signed(src2[31:0])};
    assign sltu_res = {31'd0, src1[31:0] < src2[31:0]};
    assign sll_res  = src1[31:0] << src2[4:0];
    assign srl_res  = src1[31:0] >> src2[4:0];
    assign sra_res  = word_t'($signed(src1[31:0]) >>> src2[4:0]);

    always_comb begin
        alu_out = ({32{stage_inst.alu_op[ALU_ADD]}}  & add_res)
                | ({32{stage_inst.alu_op[ALU_SUB]}}  & sub_res)
                | ({32{stage_inst.alu_op[ALU_SLT]}}  & slt_res)
                | ({32{stage_inst.alu_op[ALU_SLTU]}} & sltu_res)
                | ({32{stage_inst.alu_op[ALU_AND]}}  & (src1[31:0] & src2[31:0]))
                | ({32{stage_inst.alu_op[ALU_NOR]}}  & ~(src1[31:0] | src2[31:0]))
                | ({32{stage_inst.alu_op[ALU_OR]}}   & (src1[31:0] | src2[31:0]))
                | ({32{stage_inst.alu_op[ALU_XOR]}}  & (src1[31:0] ^ src2[31:0]))
                | ({32{stage_inst.alu_op[ALU_SLL]}}  & sll_res)
                | ({32{stage_inst.alu_op[ALU_SRL]}}  & srl_res)
                | ({32{stage_inst.alu_op[ALU_SRA]}}  & sra_res)
                | ({32{stage_inst.alu_op[ALU_LUI]}}  & src2[31:0]);
    end

    // also the load/store address
    assign alu_result = alu_out;

    // multiplier
    assign mul_prod = $signed(src1) * $signed(src2);
    assign mul_lo   = mul_prod[31:0];
    assign mul_hi   = mul_prod[63:32];

    // free-running stable counter
    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign cnt_lo = stable_cnt[31:0];
    // bits above 31, zero-extended
    assign cnt_hi = word_t'(stable_cnt >> 32);

    // result select
    always_comb begin
        result = ({32{|stage_inst.alu_op}}              & alu_out)
               | ({32{stage_inst.mul_op[MUL_LO]}}       & mul_lo)
               | ({32{stage_inst.mul_op[MUL_HI]
                    | stage_inst.mul_op[MUL_HIU]}}      & mul_hi)
               | ({32{stage_inst.rdcnt_op[RDCNT_LO]}}   & cnt_lo)
               | ({32{stage_inst.rdcnt_op[RDCNT_HI]}}   & cnt_hi);
    end

endmodule

// File: design/exe_lsu.sv
module exe_lsu (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      stage_valid,
    input  exe_ops_pkg::de_to_ex_t    stage_inst,
    input  exe_ops_pkg::word_t        addr,

    input  logic                      leaving,

    output logic                      data_req_valid,
    output data_port_pkg::data_req_t  data_req,
    input  logic                      data_addr_ok,

    output logic                      lsu_done,
    output logic                      ale,
    output logic                      req_made
);
    import exe_ops_pkg::*;
    import data_port_pkg::*;

    logic       is_mem;
    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic [1:0] offset;
    logic       accepted;
    logic       req_done;
    strb_t      st_strb;
    word_t      st_data;

    assign is_mem = stage_inst.res_from_mem | stage_inst.mem_we;
    assign offset = addr[1:0];

    assign is_byte = stage_inst.ld_op[LD_B] | stage_inst.ld_op[LD_BU] | stage_inst.st_op[ST_B];
    assign is_half = stage_inst.ld_op[LD_H] | stage_inst.ld_op[LD_HU] | stage_inst.st_op[ST_H];
    assign is_word = stage_inst.ld_op[LD_W] | stage_inst.st_op[ST_W];

    // alignment check
    assign ale = (is_half & offset[0]) | (is_word & |offset);

    // store lanes and replicated data
    always_comb begin
        if (stage_inst.st_op[ST_B]) begin
            st_strb = strb_t'(4'b0001 << offset);
            st_data = {4{stage_inst.rkd_value[7:0]}};
        end else if (stage_inst.st_op[ST_H]) begin
            st_strb = offset[1] ? STRB_HALF_HI : STRB_HALF_LO;
            st_data = {2{stage_inst.rkd_value[15:0]}};
        end else if (stage_inst.st_op[ST_W]) begin
            st_strb = STRB_WORD;
            st_data = stage_inst.rkd_value;
        end else begin
            st_strb = STRB_NONE;
            st_data = stage_inst.rkd_value;
        end
    end

    always_comb begin
        data_req.wr    = stage_inst.mem_we;
        data_req.wstrb = st_strb;
        data_req.addr  = addr;
        data_req.wdata = st_data;
        if (is_byte) begin
            data_req.size = SIZE_BYTE;
        end else if (is_half) begin
            data_req.size = SIZE_HALF;
        end else begin
            data_req.size = SIZE_WORD;
        end
    end

    // one request per instruction, never repeated under back-pressure
    assign data_req_valid = stage_valid && is_mem && !ale && !req_done;
    assign accepted       = data_req_valid && data_addr_ok;

    always_ff @(posedge clk) begin
        if (reset || leaving) begin
            req_done <= 1'b0;
        end else if (accepted) begin
            req_done <= 1'b1;
        end
    end

    assign req_made = req_done || accepted;

    // misaligned accesses pass straight through
    assign lsu_done = !is_mem || ale || req_made;

endmodule

// File: design/exe_stage.sv
module exe_stage #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  exe_ops_pkg::de_to_ex_t    in_inst,

    output logic                      out_valid,
    input  logic                      out_ready,
    output exe_ops_pkg::ex_to_mem_t   out_inst,

    output logic                      data_req_valid,
    output data_port_pkg::data_req_t  data_req,
    input  logic                      data_addr_ok,

    output exe_ops_pkg::ex_forward_t  forward
);
    import exe_ops_pkg::*;

    logic      stage_valid;
    de_to_ex_t stage_inst;
    word_t     alu_result;
    word_t     result;
    logic      lsu_done;
    logic      leaving;
    logic      ale;
    logic      req_made;

    // instruction leaves towards the memory stage this cycle
    assign leaving = out_valid && out_ready;

    exe_stage_reg u_stage_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_inst     (in_inst),
        .stage_valid (stage_valid),
        .stage_inst  (stage_inst),
        .lsu_done    (lsu_done),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    exe_compute #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) u_compute (
        .clk        (clk),
        .reset      (reset),
        .stage_inst (stage_inst),
        .alu_result (alu_result),
        .result     (result)
    );

    exe_lsu u_lsu (
        .clk            (clk),
        .reset          (reset),
        .stage_valid    (stage_valid),
        .stage_inst     (stage_inst),
        .addr           (alu_result),
        .leaving        (leaving),
        .data_req_valid (data_req_valid),
        .data_req       (data_req),
        .data_addr_ok   (data_addr_ok),
        .lsu_done       (lsu_done),
        .ale            (ale),
        .req_made       (req_made)
    );

    always_comb begin
        out_inst.pc           = stage_inst.pc;
        out_inst.result       = result;
        out_inst.dest         = stage_inst.dest;
        out_inst.gr_we        = stage_inst.gr_we;
        out_inst.res_from_mem = stage_inst.res_from_mem;
        out_inst.mem_we       = stage_inst.mem_we;
        out_inst.ld_op        = stage_inst.ld_op;
        out_inst.ls_offset    = alu_result[1:0];
        out_inst.rkd_value    = stage_inst.rkd_value;
        out_inst.ale          = ale;
        out_inst.mem_req_made = req_made;

        // loads block decode until the memory stage returns data
        forward.dest  = {5{stage_valid && stage_inst.gr_we}} & stage_inst.dest;
        forward.data  = result;
        forward.block = stage_inst.res_from_mem;
    end

endmodule

// File: testbench/exe_stage_tb.sv
module exe_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exe_ops_pkg::*;
    import data_port_pkg::*;

    // one case is one instruction sent through the stage
    localparam int NUM_CASES   = 48;
    localparam int CYCLE_LIMIT = 8 + 20 * NUM_CASES;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    de_to_ex_t   in_inst;
    logic        out_valid;
    logic        out_ready;
    ex_to_mem_t  out_inst;
    logic        data_req_valid;
    data_req_t   data_req;
    logic        data_addr_ok;
    ex_forward_t forward;

    integer seed;
    int     value_errors;
    int     handshake_errors;
    int     cycles;

    exe_stage #(.COUNTER_WIDTH(64)) u_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_result(input ex_to_mem_t got, input ex_to_mem_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_req(input data_req_t got, input data_req_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s request, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_forward(input ex_forward_t got, input ex_forward_t exp,
                                   input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s forward, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic word_t alu_model(int op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            ALU_AND:  return a & b;
            ALU_NOR:  return ~(a | b);
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            default:  return b;
        endcase
    endfunction

    function automatic word_t mul_model(int op, word_t a, word_t b);
        logic [63:0] prod;
        // low 64 bits of the sign-extended product equal the signed product
        if (op == MUL_HI) begin
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end else begin
            prod = {32'd0, a} * {32'd0, b};
        end
        return (op == MUL_LO) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic data_req_t req_model(de_to_ex_t inst, word_t addr);
        data_req_t req;
        req.wr    = inst.mem_we;
        req.addr  = addr;
        req.wstrb = 4'b0000;
        req.wdata = inst.rkd_value;
        if (inst.st_op[ST_B] || inst.ld_op[LD_B] || inst.ld_op[LD_BU]) begin
            req.size = SIZE_BYTE;
        end else if (inst.st_op[ST_H] || inst.ld_op[LD_H] || inst.ld_op[LD_HU]) begin
            req.size = SIZE_HALF;
        end else begin
            req.size = SIZE_WORD;
        end
        if (inst.st_op[ST_B]) begin
            req.wstrb = 4'b0001 << addr[1:0];
            req.wdata = {4{inst.rkd_value[7:0]}};
        end else if (inst.st_op[ST_H]) begin
            req.wstrb = addr[1] ? 4'b1100 : 4'b0011;
            req.wdata = {2{inst.rkd_value[15:0]}};
        end else if (inst.st_op[ST_W]) begin
            req.wstrb = 4'b1111;
        end
        return req;
    endfunction

    function automatic de_to_ex_t new_inst();
        de_to_ex_t inst;
        inst           = '0;
        inst.pc        = $random(seed) & 32'hffff_fffc;
        inst.dest      = reg_idx_t'($random(seed)) | 5'd1;
        inst.gr_we     = 1'b1;
        inst.rj_value  = $random(seed);
        inst.rkd_value = $random(seed);
        inst.imm       = $random(seed);
        return inst;
    endfunction

    // address is rj plus a small offset
    function automatic de_to_ex_t mem_inst(input logic [1:0] off);
        de_to_ex_t inst;
        inst                 = new_inst();
        inst.alu_op[ALU_ADD] = 1'b1;
        inst.src2_is_imm     = 1'b1;
        inst.rj_value[1:0]   = 2'b00;
        inst.imm             = word_t'(off);
        return inst;
    endfunction

    task automatic issue(input de_to_ex_t inst);
        int n;
        n        = 0;
        in_valid = 1'b1;
        in_inst  = inst;
        @(negedge clk);
        while (!in_ready && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            handshake_errors++;
            $display("the stage did not accept an instruction within 20 cycles");
        end
        @(posedge clk);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic run_inst(input de_to_ex_t inst, input word_t res, input logic ale,
                            input int ok_delay, input string what);
        logic        req;
        int          n;
        ex_to_mem_t  exp;
        ex_forward_t fwd;
        req = (inst.mem_we || inst.res_from_mem) && !ale;
        exp = {inst.pc, res, inst.dest, inst.gr_we, inst.res_from_mem, inst.mem_we,
               inst.ld_op, (|inst.alu_op) ? res[1:0] : 2'b00, inst.rkd_value, ale, req};
        fwd = {inst.gr_we ? inst.dest : 5'd0, res, inst.res_from_mem};
        n = 0;
        issue(inst);
        data_addr_ok = (ok_delay == 0);
        forever begin
            @(negedge clk);
            compare_forward(forward, fwd, what);
            compare_bit(data_req_valid, req, {what, " request valid"});
            if (req) begin
                compare_req(data_req, req_model(inst, res), what);
            end
            if (out_valid || n >= 20) break;
            @(posedge clk);
            #5;
            n++;
            data_addr_ok = (n >= ok_delay);
        end
        if (!out_valid) begin
            handshake_errors++;
            $display("%s never reached the memory stage", what);
        end else begin
            compare_bit(n == (req ? ok_delay : 0), 1'b1, {what, " out_valid timing"});
            compare_result(out_inst, exp, what);
        end
        @(posedge clk);
        #5;
        data_addr_ok = 1'b0;
    endtask

    // memory stage stalls while the instruction sits in the stage
    task automatic hold_inst(input de_to_ex_t inst, input word_t res, input string what);
        ex_to_mem_t exp;
        logic       req;
        int         reqs;
        req          = inst.mem_we || inst.res_from_mem;
        exp          = {inst.pc, res, inst.dest, inst.gr_we, inst.res_from_mem, inst.mem_we,
                        inst.ld_op, (|inst.alu_op) ? res[1:0] : 2'b00, inst.rkd_value,
                        1'b0, req};
        reqs         = 0;
        out_ready    = 1'b0;
        data_addr_ok = 1'b1;
        issue(inst);
        repeat (5) begin
            @(negedge clk);
            reqs += data_req_valid;
            compare_bit(out_valid, 1'b1, {what, " out_valid"});
            compare_bit(in_ready, 1'b0, {what, " in_ready"});
            compare_result(out_inst, exp, {what, " held"});
        end
        @(posedge clk);
        #5;
        out_ready    = 1'b1;
        data_addr_ok = 1'b0;
        @(negedge clk);
        reqs += data_req_valid;
        compare_bit(out_valid, 1'b1, {what, " out_valid released"});
        compare_result(out_inst, exp, {what, " released"});
        compare_word(word_t'(reqs), word_t'(req), {what, " request count"});
        @(posedge clk);
        #5;
    endtask

    task automatic read_counter(input int which, output word_t value);
        de_to_ex_t inst;
        inst          = new_inst();
        inst.rdcnt_op = rdcnt_op_t'(1) << which;
        issue(inst);
        @(negedge clk);
        compare_bit(out_valid, 1'b1, "counter read valid");
        value = out_inst.result;
        @(posedge clk);
        #5;
    endtask

    // second read enters on the edge where the first one leaves
    task automatic read_counter_pair(output word_t first, output word_t second,
                                     output int gap);
        de_to_ex_t inst;
        int        stamp;
        inst          = new_inst();
        inst.rdcnt_op = rdcnt_op_t'(1) << RDCNT_LO;
        issue(inst);
        in_valid = 1'b1;
        @(negedge clk);
        compare_bit(out_valid, 1'b1, "first counter read valid");
        compare_bit(in_ready, 1'b1, "in_ready while the first read leaves");
        first = out_inst.result;
        stamp = cycles;
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        @(negedge clk);
        compare_bit(out_valid, 1'b1, "second counter read valid");
        second = out_inst.result;
        gap    = cycles - stamp;
        @(posedge clk);
        #5;
    endtask

    task automatic test_alu();
        de_to_ex_t inst;
        word_t     a;
        word_t     b;
        for (int op = 0; op < 12; op++) begin
            inst             = new_inst();
            inst.alu_op      = alu_op_t'(1) << op;
            inst.src1_is_pc  = (op % 3 == 0);
            inst.src2_is_imm = (op % 2 == 1);
            a = inst.src1_is_pc ? inst.pc : inst.rj_value;
            b = inst.src2_is_imm ? inst.imm : inst.rkd_value;
            run_inst(inst, alu_model(op, a, b), 1'b0, 0, $sformatf("alu op %0d", op));
        end
    endtask

    task automatic test_mul();
        de_to_ex_t inst;
        word_t     edge_a [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_ffff};
        word_t     edge_b [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001};
        for (int i = 0; i < 6; i++) begin
            inst = new_inst();
            if (i >= 2) begin
                inst.rj_value  = edge_a[i-2];
                inst.rkd_value = edge_b[i-2];
            end
            for (int op = 0; op < 3; op++) begin
                inst.mul_op = mul_op_t'(1) << op;
                run_inst(inst, mul_model(op, inst.rj_value, inst.rkd_value), 1'b0, 0,
                         $sformatf("mul op %0d pair %0d", op, i));
            end
        end
    endtask

    task automatic test_stores();
        de_to_ex_t inst;
        for (int kind = 0; kind < 3; kind++) begin
            for (int off = 0; off < 4; off++) begin
                if ((kind == ST_H && off % 2 == 1) || (kind == ST_W && off != 0)) continue;
                inst        = mem_inst(2'(off));
                inst.gr_we  = 1'b0;
                inst.mem_we = 1'b1;
                inst.st_op  = st_op_t'(1) << kind;
                run_inst(inst, inst.rj_value + inst.imm, 1'b0, 3,
                         $sformatf("store %0d offset %0d", kind, off));
            end
        end
    endtask

    task automatic test_misaligned();
        de_to_ex_t inst;
        inst                  = mem_inst(2'd1);
        inst.res_from_mem     = 1'b1;
        inst.ld_op[LD_W]      = 1'b1;
        run_inst(inst, inst.rj_value + inst.imm, 1'b1, 0, "misaligned word load");
        inst                  = mem_inst(2'd3);
        inst.gr_we            = 1'b0;
        inst.mem_we           = 1'b1;
        inst.st_op[ST_H]      = 1'b1;
        run_inst(inst, inst.rj_value + inst.imm, 1'b1, 0, "misaligned half store");
        inst                  = mem_inst(2'd1);
        inst.res_from_mem     = 1'b1;
        inst.ld_op[LD_HU]     = 1'b1;
        run_inst(inst, inst.rj_value + inst.imm, 1'b1, 0, "misaligned half load");
    endtask

    task automatic test_back_pressure();
        de_to_ex_t inst;
        inst                 = new_inst();
        inst.alu_op[ALU_ADD] = 1'b1;
        hold_inst(inst, inst.rj_value + inst.rkd_value, "held add");
        inst                 = mem_inst(2'd0);
        inst.gr_we           = 1'b0;
        inst.mem_we          = 1'b1;
        inst.st_op[ST_W]     = 1'b1;
        hold_inst(inst, inst.rj_value + inst.imm, "held store");
    endtask

    task automatic test_forward_counter();
        de_to_ex_t inst;
        word_t     lo_first;
        word_t     lo_second;
        word_t     hi;
        int        gap;
        inst                 = new_inst();
        inst.alu_op[ALU_XOR] = 1'b1;
        run_inst(inst, inst.rj_value ^ inst.rkd_value, 1'b0, 0, "forward xor");
        inst.gr_we           = 1'b0;
        run_inst(inst, inst.rj_value ^ inst.rkd_value, 1'b0, 0, "forward no write");
        inst                 = mem_inst(2'd2);
        inst.res_from_mem    = 1'b1;
        inst.ld_op[LD_H]     = 1'b1;
        run_inst(inst, inst.rj_value + inst.imm, 1'b0, 2, "forward load");
        read_counter_pair(lo_first, lo_second, gap);
        compare_word(lo_second - lo_first, word_t'(gap), "counter step");
        read_counter(RDCNT_HI, hi);
        compare_word(hi, 32'd0, "counter high word");
    endtask

    initial begin
        seed         = 32'he8c3;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        out_ready    = 1'b1;
        data_addr_ok = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        compare_bit(in_ready, 1'b1, "in_ready after reset");
        compare_bit(out_valid, 1'b0, "out_valid after reset");
        compare_bit(data_req_valid, 1'b0, "request valid after reset");
        test_alu();
        test_mul();
        test_stores();
        test_misaligned();
        test_back_pressure();
        test_forward_counter();
        $display("errors: %0d value, %0d handshake", value_errors, handshake_errors);
        if (value_errors + handshake_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: exe_stage.f
design/exe_ops_pkg.sv
design/data_port_pkg.sv
design/exe_stage_reg.sv
design/exe_compute.sv
design/exe_lsu.sv
design/exe_stage.sv
testbench/exe_stage_tb.sv
